// ==== sim.f ====
hdl/trace_pkg.sv
hdl/word_fetch.sv
hdl/segment_extract.sv
hdl/record_assemble.sv
hdl/trace_parse.sv
test/tb_trace_parse.sv

// ==== Bender.yml ====
package:
  name: trace_parse

sources:
  - files:
      - hdl/trace_pkg.sv
      - hdl/word_fetch.sv
      - hdl/segment_extract.sv
      - hdl/record_assemble.sv
      - hdl/trace_parse.sv
  - target: test
    files:
      - test/tb_trace_parse.sv

// ==== test/tb_trace_parse.sv ====
module tb_trace_parse;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_half = 20;
    // quiet cycles that must follow the last record
    localparam int idle_cycles = 50;
    localparam logic [31:0] lfsr_seed = 32'h2b0b_e2e9;
    // taps 32, 22, 2, 1
    localparam logic [31:0] lfsr_mask = 32'h8020_0003;

    logic clk;
    logic sync_rst_n;
    trace_pkg::word_t in_data;
    logic in_empty;
    logic in_rd_en;
    trace_pkg::unit_t out_data;
    logic out_wr_en;
    logic out_almfull;
    trace_pkg::trace_bits_t trace_bits;

    logic [31:0] lfsr_state;
    // input FIFO model whose front word is on in_data
    trace_pkg::word_t in_fifo[$];
    // records in trace order with their lengths in bits
    trace_pkg::unit_t exp_rec[$];
    int exp_len[$];
    int cycle_cnt;
    int cycle_limit;
    int wr_cnt;

    trace_parse #(
        .pad_enable (1'b1)
    ) u_trace_parse (
        .clk         (clk),
        .sync_rst_n  (sync_rst_n),
        .in_data     (in_data),
        .in_empty    (in_empty),
        .in_rd_en    (in_rd_en),
        .out_data    (out_data),
        .out_wr_en   (out_wr_en),
        .out_almfull (out_almfull),
        .trace_bits  (trace_bits)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // limit grows with every trace that is built
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            fail_run($sformatf("timeout after %0d cycles with %0d records never written",
                               cycle_limit, exp_rec.size()));
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] nxt;
        nxt = state >> 1;
        if (state[0]) begin
            nxt = nxt ^ lfsr_mask;
        end
        return nxt;
    endfunction

    // one step per bit taken
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        int i;
        val = '0;
        for (i = 0; i < n; i++) begin
            val[i] = lfsr_bit();
        end
        return val;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'(rand_bits(8)) % (hi - lo + 1);
    endfunction

    // random records packed lsb first into words with the last word zero filled
    task automatic build_trace(input int num_recs, input int lo_units, input int hi_units);
        trace_pkg::unit_t rec;
        trace_pkg::word_t cur;
        int len;
        int fill;
        int total;
        int r;
        int b;
        in_fifo.delete();
        exp_rec.delete();
        exp_len.delete();
        cur = '0;
        fill = 0;
        total = 0;
        for (r = 0; r < num_recs; r++) begin
            len = rand_range(lo_units, hi_units) * trace_pkg::align_width;
            rec = '0;
            // header field holds the length in bits
            rec[trace_pkg::len_width-1:0] = trace_pkg::bit_len_t'(len);
            for (b = trace_pkg::len_width; b < len; b++) begin
                rec[b] = lfsr_bit();
            end
            for (b = 0; b < len; b++) begin
                cur[fill] = rec[b];
                fill++;
                if (fill == trace_pkg::word_width) begin
                    in_fifo.push_back(cur);
                    cur = '0;
                    fill = 0;
                end
            end
            exp_rec.push_back(rec);
            exp_len.push_back(len);
            total += len;
        end
        if (fill != 0) begin
            in_fifo.push_back(cur);
        end
        trace_bits = trace_pkg::trace_bits_t'(total);
        cycle_limit += 4 * (in_fifo.size() + num_recs);
    endtask

    // reset with the FIFO empty and a few idle cycles after it
    task automatic apply_reset();
        int i;
        sync_rst_n = 1'b0;
        in_empty = 1'b1;
        in_data = '0;
        out_almfull = 1'b0;
        for (i = 0; i < 5; i++) begin
            @(negedge clk);
            assert (!in_rd_en) else fail_run("in_rd_en high during reset or with in_empty high");
            assert (!out_wr_en) else fail_run("out_wr_en high during reset or before any input");
            // release after 2 cycles with the FIFO still empty
            if (i == 1) begin
                sync_rst_n = 1'b1;
            end
        end
    endtask

    task automatic check_record();
        trace_pkg::unit_t exp;
        trace_pkg::unit_t got;
        trace_pkg::unit_t mask;
        int len;
        exp = exp_rec.pop_front();
        len = exp_len.pop_front();
        // bits above the length are stale
        mask = trace_pkg::unit_t'('1) >> (trace_pkg::unit_width - len);
        got = out_data & mask;
        wr_cnt++;
        assert (got == exp) else begin
            fail_run($sformatf("** Error out_data record %0d: expected %h, got %h",
                               wr_cnt, exp, got));
        end
    endtask

    // outputs checked and inputs driven on the falling edge
    task automatic run_cycle(input logic stall_en);
        logic stall_in;
        @(negedge clk);
        if (out_wr_en) begin
            assert (exp_rec.size() > 0) else fail_run("record written after the end of the trace");
            check_record();
        end
        stall_in = 1'b0;
        out_almfull = 1'b0;
        if (stall_en) begin
            // each flag high one cycle in four
            stall_in = rand_bits(2) == 0;
            out_almfull = rand_bits(2) == 0;
        end
        in_empty = (in_fifo.size() == 0) || stall_in;
        in_data = (in_fifo.size() != 0) ? in_fifo[0] : '0;
        // let in_rd_en settle before the DUT takes the word on the next rising edge
        #1;
        assert (!(in_rd_en && (in_empty || out_almfull))) else fail_run("read while stalled");
        if (in_rd_en) begin
            void'(in_fifo.pop_front());
        end
    endtask

    task automatic run_test(input int num_recs, input int lo_units, input int hi_units,
                            input logic stall_en);
        @(negedge clk);
        build_trace(num_recs, lo_units, hi_units);
        apply_reset();
        wr_cnt = 0;
        while (exp_rec.size() > 0) begin
            run_cycle(stall_en);
        end
        // the pad word must not cause any extra write
        repeat (idle_cycles) begin
            run_cycle(stall_en);
        end
        assert (in_fifo.size() == 0) else fail_run("input words left unread after the trace");
    endtask

    initial begin
        sync_rst_n = 1'b0;
        in_data = '0;
        in_empty = 1'b1;
        out_almfull = 1'b0;
        trace_bits = '0;
        lfsr_state = lfsr_seed;
        cycle_cnt = 0;
        cycle_limit = 200;
        wr_cnt = 0;

        // short records of which many straddle a word boundary
        run_test(40, 2, 8, 1'b0);
        // long records spanning up to five words
        run_test(30, 9, 32, 1'b0);
        // lone record that only the pad word pushes out
        run_test(1, 2, 32, 1'b0);
        // mixed lengths with random almost-full and empty gaps
        run_test(40, 2, 32, 1'b1);

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== hdl/trace_parse.sv ====
module trace_parse #(
    parameter bit pad_enable = 1'b1
) (
    input  logic                   clk,
    input  logic                   sync_rst_n,

    // input FIFO, first-word-fall-through
    input  trace_pkg::word_t       in_data,
    input  logic                   in_empty,
    output logic                   in_rd_en,

    // output FIFO, one record per write
    output trace_pkg::unit_t       out_data,
    output logic                   out_wr_en,
    input  logic                   out_almfull,

    // trace size in bits, stable for the whole run
    input  trace_pkg::trace_bits_t trace_bits
);

    // high half of the shift buffer
    trace_pkg::word_t hi_word;
    logic hi_full;
    // high half moves into the low half
    logic hi_lo_shift;

    // registered segments towards the assembler
    logic seg_valid;
    trace_pkg::word_t seg_data;
    trace_pkg::bit_len_t seg_len;

    // fetch words into the high half, pad at the end
    word_fetch #(
        .pad_enable (pad_enable)
    ) u_word_fetch (
        .clk         (clk),
        .sync_rst_n  (sync_rst_n),
        .in_data     (in_data),
        .in_empty    (in_empty),
        .out_almfull (out_almfull),
        .hi_lo_shift (hi_lo_shift),
        .trace_bits  (trace_bits),
        .in_rd_en    (in_rd_en),
        .hi_full     (hi_full),
        .hi_word     (hi_word)
    );

    // walk record boundaries in the low half
    segment_extract u_segment_extract (
        .clk         (clk),
        .sync_rst_n  (sync_rst_n),
        .hi_word     (hi_word),
        .hi_full     (hi_full),
        .trace_bits  (trace_bits),
        .hi_lo_shift (hi_lo_shift),
        .seg_valid   (seg_valid),
        .seg_data    (seg_data),
        .seg_len     (seg_len)
    );

    // collect segments into whole records
    record_assemble u_record_assemble (
        .clk        (clk),
        .sync_rst_n (sync_rst_n),
        .seg_valid  (seg_valid),
        .seg_data   (seg_data),
        .seg_len    (seg_len),
        .out_wr_en  (out_wr_en),
        .out_data   (out_data)
    );

endmodule

// ==== hdl/record_assemble.sv ====
module record_assemble (
    input  logic                clk,
    input  logic                sync_rst_n,
    input  logic                seg_valid,
    input  trace_pkg::word_t    seg_data,
    input  trace_pkg::bit_len_t seg_len,
    output logic                out_wr_en,
    output trace_pkg::unit_t    out_data
);

    // assembler state
    // asm_wait_header idle, next segment is a header
    // asm_wait_body   header in, more words to come
    // asm_done        record complete, written this cycle
    typedef enum logic [1:0] {
        asm_wait_header,
        asm_wait_body,
        asm_done
    } asm_state_t;

    localparam int word_shift = trace_pkg::word_off_width + trace_pkg::align_bits;
    localparam int slot_bits = $clog2(trace_pkg::max_words);

    asm_state_t asm_state;
    asm_state_t asm_state_next;

    // words collected so far, up to max_words
    logic [slot_bits:0] word_cnt;
    // slot the next body word goes to
    logic [slot_bits-1:0] word_idx;
    // bits covered once the incoming body word lands
    trace_pkg::bit_len_t covered_bits;
    // length of the record being assembled
    trace_pkg::bit_len_t rec_len;
    // a segment here opens a new record
    logic start_rec;

    assign word_idx = word_cnt[slot_bits-1:0];
    assign covered_bits = trace_pkg::bit_len_t'(word_cnt + 1'b1) << word_shift;

    // done also accepts the next header, no stall since almfull holds reads
    assign start_rec = seg_valid && (asm_state != asm_wait_body);

    always_comb begin
        asm_state_next = asm_state;
        case (asm_state)
            asm_wait_header, asm_done: begin
                if (seg_valid) begin
                    // one-word record completes at once
                    if (seg_len <= trace_pkg::bit_len_t'(trace_pkg::word_width)) begin
                        asm_state_next = asm_done;
                    end else begin
                        asm_state_next = asm_wait_body;
                    end
                end else begin
                    asm_state_next = asm_wait_header;
                end
            end
            asm_wait_body: begin
                if (seg_valid && (rec_len <= covered_bits)) begin
                    asm_state_next = asm_done;
                end
            end
            default: asm_state_next = asm_wait_header;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            asm_state <= asm_wait_header;
        end else begin
            asm_state <= asm_state_next;
        end
    end

    // word count and latched length
    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            word_cnt <= '0;
            rec_len <= '0;
        end else if (start_rec) begin
            word_cnt <= 1'b1;
            rec_len <= seg_len;
        end else if (seg_valid) begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    // record buffer feeds the output FIFO directly
    // bits above rec_len keep whatever an older record left
    always_ff @(posedge clk) begin
        if (start_rec) begin
            out_data[0 +: trace_pkg::word_width] <= seg_data;
        end else if (seg_valid) begin
            out_data[word_idx*trace_pkg::word_width +: trace_pkg::word_width] <= seg_data;
        end
    end

    // one write per finished record
    assign out_wr_en = asm_state == asm_done;

endmodule

// ==== hdl/segment_extract.sv ====
module segment_extract (
    input  logic                   clk,
    input  logic                   sync_rst_n,
    input  trace_pkg::word_t       hi_word,
    input  logic                   hi_full,
    input  trace_pkg::trace_bits_t trace_bits,
    output logic                   hi_lo_shift,
    output logic                   seg_valid,
    output trace_pkg::word_t       seg_data,
    output trace_pkg::bit_len_t    seg_len
);

    // low half state
    // lo_empty  nothing valid yet
    // lo_header a record header starts at lo_off
    // lo_body   the rest of a record starts at lo_off
    typedef enum logic [1:0] {
        lo_empty,
        lo_header,
        lo_body
    } lo_state_t;

    localparam int trace_msb = $bits(trace_pkg::trace_bits_t) - 1;

    lo_state_t lo_state;
    lo_state_t lo_state_next;

    // low half payload and the unit offset into it
    trace_pkg::word_t lo_word;
    trace_pkg::word_off_t lo_off;

    // both halves side by side, low half in the lsbs
    logic [2*trace_pkg::word_width-1:0] shift_buf;
    // word-wide window starting at lo_off
    trace_pkg::word_t lo_out_data;

    // units of the current record still to send
    trace_pkg::alen_t lo_remain_len;
    // body count, one word less after each full segment
    trace_pkg::alen_t lo_remain_reg;
    // units that leave with the current segment
    trace_pkg::alen_t lo_sent_units;

    // segment leaves the low half this cycle
    logic lo_out;
    // record ends inside this segment
    logic lo_satisfied;
    // segment reaches to or past the end of the low half
    logic lo_exhaust;
    // whole trace has been sent, the rest is padding
    logic lo_done;

    // emitted alignment units and the trace size in units
    trace_pkg::unit_cnt_t unit_cnt;
    trace_pkg::unit_cnt_t unit_total;

    assign shift_buf = {hi_word, lo_word};
    assign lo_out_data = shift_buf[lo_off*trace_pkg::align_width +: trace_pkg::word_width];

    // header length comes straight from the window, body from the register
    always_comb begin
        case (lo_state)
            lo_header: lo_remain_len = lo_out_data[trace_pkg::align_bits +: trace_pkg::alen_width];
            lo_body:   lo_remain_len = lo_remain_reg;
            default:   lo_remain_len = '0;
        endcase
    end

    assign lo_satisfied = lo_remain_len <= trace_pkg::alen_t'(trace_pkg::word_units);

    // one extra bit so offset plus length never wraps
    assign lo_exhaust = ({1'b0, lo_remain_len} + (trace_pkg::alen_width + 1)'(lo_off)) >=
                        (trace_pkg::alen_width + 1)'(trace_pkg::word_units);

    assign lo_sent_units = lo_satisfied ? lo_remain_len :
                           trace_pkg::alen_t'(trace_pkg::word_units);

    assign unit_total = trace_bits[trace_msb:trace_pkg::align_bits];
    assign lo_done = unit_cnt == unit_total;

    // window spans both halves, so the high half must hold data
    assign lo_out = hi_full && (lo_state != lo_empty) && !lo_done;

    // refill the low half when empty or fully consumed
    assign hi_lo_shift = hi_full && ((lo_state == lo_empty) || (lo_out && lo_exhaust));

    // low state machine
    always_comb begin
        lo_state_next = lo_state;
        case (lo_state)
            lo_empty: begin
                if (hi_lo_shift) begin
                    lo_state_next = lo_header;
                end
            end
            lo_header, lo_body: begin
                if (hi_lo_shift) begin
                    // record ends here or carries on into the next word
                    lo_state_next = lo_satisfied ? lo_header : lo_body;
                end else if (lo_out) begin
                    // record ended inside the low half, next header follows
                    lo_state_next = lo_header;
                end
            end
            default: lo_state_next = lo_empty;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            lo_state <= lo_empty;
        end else begin
            lo_state <= lo_state_next;
        end
    end

    // offset moves only when a record ends, a full word keeps it
    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            lo_off <= '0;
        end else if (lo_state == lo_empty) begin
            lo_off <= '0;
        end else if (lo_out && lo_satisfied) begin
            // wraps mod word_units when the record crosses into the next word
            lo_off <= lo_off + lo_remain_len[trace_pkg::word_off_width-1:0];
        end
    end

    // remaining body units, only read in lo_body
    always_ff @(posedge clk) begin
        if (hi_lo_shift && (lo_state != lo_empty) && !lo_satisfied) begin
            lo_remain_reg <= lo_remain_len - trace_pkg::alen_t'(trace_pkg::word_units);
        end
    end

    // low half payload
    always_ff @(posedge clk) begin
        if (hi_lo_shift) begin
            lo_word <= hi_word;
        end
    end

    // emitted unit counter
    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            unit_cnt <= '0;
        end else if (lo_out) begin
            unit_cnt <= unit_cnt + trace_pkg::unit_cnt_t'(lo_sent_units);
        end
    end

    // register barrier towards the assembler
    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            seg_valid <= 1'b0;
        end else begin
            seg_valid <= lo_out;
        end
    end

    always_ff @(posedge clk) begin
        seg_data <= lo_out_data;
        // units back to bits, only meaningful with a header
        seg_len <= {lo_remain_len, {trace_pkg::align_bits{1'b0}}};
    end

endmodule

// ==== hdl/word_fetch.sv ====
module word_fetch #(
    parameter bit pad_enable = 1'b1
) (
    input  logic                   clk,
    input  logic                   sync_rst_n,
    input  trace_pkg::word_t       in_data,
    input  logic                   in_empty,
    input  logic                   out_almfull,
    input  logic                   hi_lo_shift,
    input  trace_pkg::trace_bits_t trace_bits,
    output logic                   in_rd_en,
    output logic                   hi_full,
    output trace_pkg::word_t       hi_word
);

    // bits of a bit position inside one word
    localparam int word_shift = trace_pkg::word_off_width + trace_pkg::align_bits;
    localparam int trace_msb = $bits(trace_pkg::trace_bits_t) - 1;

    // words taken so far, the pad word counts too
    trace_pkg::word_cnt_t word_cnt;
    // trace size rounded up to whole words
    trace_pkg::word_cnt_t words_total;

    // high half can take a word this cycle
    logic hi_room;
    // all trace words are in, zero word still owed
    logic pad_due;
    // zero word goes into the high half this cycle
    logic hi_pad;
    // any load of the high half
    logic hi_load;

    // ceiling of trace_bits over the word width
    assign words_total = trace_bits[trace_msb:word_shift] +
                         trace_pkg::word_cnt_t'(|trace_bits[word_shift-1:0]);

    // free now, or emptied into the low half on this edge
    assign hi_room = !hi_full || hi_lo_shift;

    // first-word-fall-through read, data taken on the same edge
    // almost-full only throttles reads, words in flight keep moving
    assign in_rd_en = !in_empty && !out_almfull && hi_room;

    // counter stops matching once the pad is loaded, so only one pad
    assign pad_due = pad_enable && (word_cnt != '0) && (word_cnt == words_total);

    // a real word wins if the FIFO still offers one
    assign hi_pad = pad_due && hi_room && !in_rd_en;

    assign hi_load = in_rd_en || hi_pad;

    // high half occupancy
    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            hi_full <= 1'b0;
        end else if (hi_load) begin
            // load, or flow when a shift happens on the same edge
            hi_full <= 1'b1;
        end else if (hi_lo_shift) begin
            // unload into the low half
            hi_full <= 1'b0;
        end
    end

    // input word counter
    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            word_cnt <= '0;
        end else if (hi_load) begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    // high half payload, qualified by hi_full
    always_ff @(posedge clk) begin
        if (in_rd_en) begin
            hi_word <= in_data;
        end else if (hi_pad) begin
            // zero word pushes the last record out of the low half
            hi_word <= '0;
        end
    end

endmodule

// ==== hdl/trace_pkg.sv ====
package trace_pkg;

    // one input word as read from the trace FIFO
    localparam int word_width = 64;

    // records are always whole multiples of this unit
    localparam int align_width = 8;

    // largest record, also the width of the output FIFO word
    localparam int unit_width = 256;

    // record length in bits, sized to hold unit_width itself
    localparam int len_width = 9;

    // bit position inside one alignment unit
    localparam int align_bits = 3;

    // record length counted in alignment units, header bits 3 to 8
    localparam int alen_width = 6;

    // alignment units per word and the offset that walks them
    localparam int word_units = 8;
    localparam int word_off_width = 3;

    // words needed for the largest record
    localparam int max_words = 4;

    typedef logic [word_width-1:0] word_t;
    typedef logic [unit_width-1:0] unit_t;
    typedef logic [len_width-1:0] bit_len_t;
    typedef logic [alen_width-1:0] alen_t;
    typedef logic [word_off_width-1:0] word_off_t;

    // trace size and the counters derived from it
    typedef logic [31:0] trace_bits_t;
    typedef logic [31-word_off_width-align_bits:0] word_cnt_t;
    typedef logic [31-align_bits:0] unit_cnt_t;

endpackage
